// File: dv/fetch_patterns.txt
// Records of three hex words: cmd a b
// cmd 2 fill (a seed), 1 load (a addr, b word), 3 run (a count, b ready %), 4 stop, 0 end
2 5A5A0000 00000000
1 00000200 00000013
1 00000204 00100093
1 00000208 00200113
1 0000020C 002081B3
1 00000210 40110233
1 00000224 0041A023
// 20 instructions, decode always ready
3 00000014 00000064
4 00000000 00000000
// Reload while stopped, low addresses alias the same words
1 0000000C 0000006F
1 00000304 FEDCBA98
1 000002FC 00008067
1 00000258 12345678
1 00000284 0000A503
// 60 more with 50 percent ready, passes 0x300 and wraps
3 0000003C 00000032
4 00000000 00000000
// Short restart
3 00000004 00000064
4 00000000 00000000
0 00000000 00000000

// File: build.f
hdl/fetch_pkg.sv
hdl/mem_if.sv
hdl/fd_if.sv
hdl/fetch_unit.sv
hdl/inst_mem.sv
hdl/fetch_top.sv
dv/fetch_clk_gen.sv
dv/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/mem_if.sv
      - hdl/fd_if.sv
      - hdl/fetch_unit.sv
      - hdl/inst_mem.sv
      - hdl/fetch_top.sv
  - target: test
    files:
      - dv/fetch_clk_gen.sv
      - dv/tb_fetch_top.sv

// File: dv/tb_fetch_top.sv
// Fetch front end testbench
// Loads a program from the pattern file, runs fetch under decode
// back-pressure and checks pc, seq and inst of every instruction

`timescale 1ns/100ps

module tb_fetch_top;

  localparam int unsigned MEM_WORDS = 64;
  localparam int unsigned PAT_WORDS = 192;
  localparam logic [31:0] START_PC  = 32'h0000_0200;

  logic             clk;
  logic             rst;
  logic             run;
  logic             load_val;
  fetch_pkg::addr_t load_addr;
  fetch_pkg::word_t load_data;
  logic             d_val;
  logic             d_rdy;
  fetch_pkg::word_t d_inst;
  fetch_pkg::addr_t d_pc;
  fetch_pkg::seq_t  d_seq;

  // Reference model and pattern records
  logic [31:0] model [MEM_WORDS];
  logic [31:0] pat [PAT_WORDS];
  logic [31:0] exp_pc;
  logic [7:0]  exp_seq;
  int unsigned accepted;
  int unsigned errors;
  int unsigned wd_cycles;

  fetch_clk_gen i_clk_gen (.clk(clk), .rst(rst));

  fetch_top #(
    .MEM_WORDS  (MEM_WORDS),
    .RESET_ADDR (START_PC)
  ) i_fetch_top (
    .clk (clk), .rst (rst), .run (run),
    .load_val (load_val), .load_addr (load_addr), .load_data (load_data),
    .d_val (d_val), .d_rdy (d_rdy), .d_inst (d_inst), .d_pc (d_pc), .d_seq (d_seq)
  );

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  // Transfer at the coming edge against the next expected instruction
  task automatic check_instruction();
    logic [31:0] exp_inst;
    exp_inst = model[(exp_pc >> 2) % MEM_WORDS];
    if (d_pc !== exp_pc) begin
      errors++;
      $display("** Error at %0t ns: pc expected %h, got %h", $time, exp_pc, d_pc);
    end
    if (d_seq !== exp_seq) begin
      errors++;
      $display("** Error at %0t ns: seq expected %0d, got %0d", $time, exp_seq, d_seq);
    end
    if (d_inst !== exp_inst) begin
      errors++;
      $display("** Error at %0t ns: inst expected %h, got %h", $time, exp_inst, d_inst);
    end
    exp_pc  = exp_pc + 32'd4;
    exp_seq = exp_seq + 8'd1;
    accepted++;
  endtask

  // ------------------------------------------------------------
  // Stimulus steps on the falling edge
  // ------------------------------------------------------------

  task automatic fetch_cycle(input logic run_v, input int unsigned rdy_pct);
    @(negedge clk);
    load_val = 1'b0;
    run      = run_v;
    d_rdy    = (($urandom % 100) < rdy_pct);
    if (d_val === 1'b1 && d_rdy) check_instruction();
  endtask

  // Decode must see nothing while fetch is stopped
  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    run       = 1'b0;
    load_val  = 1'b1;
    load_addr = addr;
    load_data = data;
    model[(addr >> 2) % MEM_WORDS] = data;
    if (d_val !== 1'b0) begin
      errors++;
      $display("** Error at %0t ns: d_val %b while fetch is stopped", $time, d_val);
    end
  endtask

  // Whole-address hash so aliased words are told apart
  task automatic fill_memory(input logic [31:0] seed);
    logic [31:0] addr;
    for (int unsigned i = 0; i < MEM_WORDS; i++) begin
      addr = START_PC + 4 * i;
      load_word(addr, (addr * 32'h9E37_79B1) ^ seed);
    end
  endtask

  task automatic run_for(input int unsigned count, input int unsigned rdy_pct);
    int unsigned target;
    target = accepted + count;
    while (accepted < target) fetch_cycle(1'b1, rdy_pct);
  endtask

  // Drop run and drain whatever is still in flight
  task automatic stop_fetch();
    int unsigned quiet;
    quiet = 0;
    while (quiet < 3) begin
      fetch_cycle(1'b0, 100);
      if (d_val === 1'b1) quiet = 0;
      else quiet++;
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    int unsigned seed_val;
    int unsigned idx;
    int unsigned total;
    run = 1'b0;
    load_val = 1'b0;
    load_addr = '0;
    load_data = '0;
    d_rdy = 1'b0;
    exp_pc = START_PC;
    exp_seq = '0;
    accepted = 0;
    errors = 0;
    wd_cycles = 0;
    // One seed for the whole run
    seed_val = 92;
    seed_val = $urandom(seed_val);
    for (idx = 0; idx < PAT_WORDS; idx++) pat[idx] = '0;
    $readmemh("dv/fetch_patterns.txt", pat);
    // Watchdog budget from the requested instruction counts
    total = 0;
    for (idx = 0; idx < PAT_WORDS; idx += 3) begin
      if (pat[idx] == 32'd3) total += pat[idx+1];
    end
    wd_cycles = 40 * total + 200;
    // Through reset decode stays idle
    while (rst !== 1'b0) begin
      @(negedge clk);
      if (d_val !== 1'b0) begin
        errors++;
        $display("** Error at %0t ns: d_val %b during reset", $time, d_val);
      end
    end
    idx = 0;
    while (idx + 2 < PAT_WORDS && pat[idx] != 32'd0) begin
      case (pat[idx])
        32'd1: load_word(pat[idx+1], pat[idx+2]);
        32'd2: fill_memory(pat[idx+1]);
        32'd3: run_for(pat[idx+1], pat[idx+2]);
        32'd4: stop_fetch();
        default: begin
          errors++;
          $display("Unknown command %h in the pattern file at word %0d", pat[idx], idx);
        end
      endcase
      idx += 3;
    end
    $display("Checked %0d instructions with %0d errors", accepted, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: the instruction stream did not finish in %0d cycles", wd_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: dv/fetch_clk_gen.sv
// Testbench clock and reset
// 8 ns clock, reset held over the first two rising edges

`timescale 1ns/100ps

module fetch_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

// File: hdl/fetch_top.sv
// Fetch front end top
// Joins fetch unit and instruction memory, exposes load and decode ports

`timescale 1ns/100ps

module fetch_top #(
  parameter int unsigned      MEM_WORDS  = 64,
  parameter fetch_pkg::addr_t RESET_ADDR = fetch_pkg::RST_ADDR
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,

  // Program load
  input  logic              load_val,
  input  fetch_pkg::addr_t  load_addr,
  input  fetch_pkg::word_t  load_data,

  // Decode channel
  output logic              d_val,
  input  logic              d_rdy,
  output fetch_pkg::word_t  d_inst,
  output fetch_pkg::addr_t  d_pc,
  output fetch_pkg::seq_t   d_seq
);

  // ----------------------------------------------------------
  // Internal channels
  // ----------------------------------------------------------

  mem_if mem_bus ();
  fd_if  fd_bus ();

  fetch_unit #(
    .RESET_ADDR (RESET_ADDR)
  ) i_fetch_unit (
    .clk  (clk),
    .rst  (rst),
    .run  (run),
    .mem  (mem_bus.client),
    .dec  (fd_bus.fetch)
  );

  inst_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) i_inst_mem (
    .clk        (clk),
    .rst        (rst),
    .load_val   (load_val),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .mem        (mem_bus.server)
  );

  // Decode side of the channel is the top-level ports
  assign d_val      = fd_bus.val;
  assign d_inst     = fd_bus.inst;
  assign d_pc       = fd_bus.pc;
  assign d_seq      = fd_bus.seq;
  assign fd_bus.rdy = d_rdy;

endmodule

// File: hdl/inst_mem.sv
// Instruction memory
// Word-addressed storage with a program load port, one-cycle read
// and a two-entry response FIFO limited by credit

`timescale 1ns/100ps

module inst_mem #(
  parameter int unsigned MEM_WORDS = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              load_val,
  input  fetch_pkg::addr_t  load_addr,
  input  fetch_pkg::word_t  load_data,
  mem_if.server             mem
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // ----------------------------------------------------------
  // Storage and load port
  // ----------------------------------------------------------

  fetch_pkg::word_t store [MEM_WORDS];

  logic [IDX_W-1:0] load_idx;
  logic [IDX_W-1:0] req_idx;

  // Word index wraps modulo depth
  assign load_idx = load_addr[IDX_W+1:2];
  assign req_idx  = mem.req_addr[IDX_W+1:2];

  // Load lands at the edge, so reads see it from the next edge on
  always_ff @(posedge clk) begin
    if (load_val) begin
      store[load_idx] <= load_data;
    end
  end

  // ----------------------------------------------------------
  // Response FIFO
  // ----------------------------------------------------------

  fetch_pkg::word_t fifo_data [2];
  fetch_pkg::addr_t fifo_addr [2];
  fetch_pkg::seq_t  fifo_tag  [2];

  logic       wr_ptr;
  logic       rd_ptr;
  // Entries held, counting the read landing this cycle
  logic [1:0] occ;
  logic       push;
  logic       pop;

  assign push = mem.req_val & mem.req_rdy;
  assign pop  = mem.resp_val & mem.resp_rdy;

  // One slot reserved per outstanding read
  assign mem.req_rdy = (occ < 2'd2);

  // Read happens on the accepting edge straight into the slot
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_data[wr_ptr] <= store[req_idx];
      fifo_addr[wr_ptr] <= mem.req_addr;
      fifo_tag[wr_ptr]  <= mem.req_tag;
    end
  end

  // Pointers and count
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      occ    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({push, pop})
        2'b10:   occ <= occ + 2'd1;
        2'b01:   occ <= occ - 2'd1;
        default: occ <= occ;
      endcase
    end
  end

  // Head of FIFO held until taken
  assign mem.resp_val  = (occ != 2'd0);
  assign mem.resp_data = fifo_data[rd_ptr];
  assign mem.resp_addr = fifo_addr[rd_ptr];
  assign mem.resp_tag  = fifo_tag[rd_ptr];

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  // Program loading only while fetch is stopped
  a_no_load_during_fetch: assert property (@(posedge clk) disable iff (rst)
    !(load_val && push))
    else $error("load collides with an accepted read");

  // A write never lands on an entry still waiting to be read
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> (occ == 2'd0 || wr_ptr != rd_ptr))
    else $error("response FIFO overflow");

endmodule

// File: hdl/fetch_unit.sv
// Fetch unit
// Sequential pc generator that tags each read with a sequence number,
// forwards memory responses straight through to decode

`timescale 1ns/100ps

module fetch_unit #(
  parameter fetch_pkg::addr_t RESET_ADDR = fetch_pkg::RST_ADDR
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     run,
  mem_if.client    mem,
  fd_if.fetch      dec
);

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------

  fetch_pkg::addr_t pc;
  fetch_pkg::seq_t  seq;
  logic             req_xfer;
  logic             resp_xfer;

  assign req_xfer  = mem.req_val & mem.req_rdy;
  assign resp_xfer = mem.resp_val & mem.resp_rdy;

  // Issue whenever fetch is enabled, no wait on ready
  assign mem.req_val  = run;
  assign mem.req_addr = pc;
  assign mem.req_tag  = seq;

  // Pc and tag step together on each accepted read
  always_ff @(posedge clk) begin
    if (rst) begin
      pc  <= RESET_ADDR;
      seq <= '0;
    end else if (req_xfer) begin
      pc  <= pc + fetch_pkg::WORD_BYTES;
      // Wraps naturally at 8 bits
      seq <= seq + 8'd1;
    end
  end

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------

  // Zero-latency pass-through to decode
  assign dec.val      = mem.resp_val;
  assign dec.inst     = mem.resp_data;
  assign dec.pc       = mem.resp_addr;
  assign dec.seq      = mem.resp_tag;
  assign mem.resp_rdy = dec.rdy;

  // Reads issued but not yet returned to decode
  logic [1:0] in_flight;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({req_xfer, resp_xfer})
        2'b10:   in_flight <= in_flight + 2'd1;
        2'b01:   in_flight <= in_flight - 2'd1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Memory must not produce a response it was never asked for
  a_resp_has_req: assert property (@(posedge clk) disable iff (rst)
    mem.resp_val |-> (in_flight != 2'd0))
    else $error("response valid with no read outstanding");

endmodule

// File: hdl/fd_if.sv
// Fetch to decode channel
// Instruction, pc and sequence number under valid/ready

`timescale 1ns/100ps

interface fd_if;

  logic               val;
  logic               rdy;
  fetch_pkg::word_t   inst;
  fetch_pkg::addr_t   pc;
  fetch_pkg::seq_t    seq;

  // Producer end
  modport fetch (
    output val, inst, pc, seq,
    input  rdy
  );

  // Consumer end
  modport decode (
    input  val, inst, pc, seq,
    output rdy
  );

endinterface

// File: hdl/mem_if.sv
// Instruction memory channel
// Read request with opaque tag, response carries data, address and tag back

`timescale 1ns/100ps

interface mem_if;

  // Request side
  logic               req_val;
  logic               req_rdy;
  fetch_pkg::addr_t   req_addr;
  fetch_pkg::seq_t    req_tag;

  // Response side
  logic               resp_val;
  logic               resp_rdy;
  fetch_pkg::addr_t   resp_addr;
  fetch_pkg::word_t   resp_data;
  fetch_pkg::seq_t    resp_tag;

  // Fetch unit end
  modport client (
    output req_val, req_addr, req_tag, resp_rdy,
    input  req_rdy, resp_val, resp_addr, resp_data, resp_tag
  );

  // Memory end
  modport server (
    input  req_val, req_addr, req_tag, resp_rdy,
    output req_rdy, resp_val, resp_addr, resp_data, resp_tag
  );

endinterface

// File: hdl/fetch_pkg.sv
// Fetch front end shared definitions
// Word, address and sequence types plus fetch defaults

package fetch_pkg;

  // ----------------------------------------------------------
  // Data widths
  // ----------------------------------------------------------

  // Instruction or data word
  typedef logic [31:0] word_t;

  // Byte address, word aligned for fetch
  typedef logic [31:0] addr_t;

  // Fetch sequence number, wraps 255 -> 0
  typedef logic [7:0] seq_t;

  // ----------------------------------------------------------
  // Fetch defaults
  // ----------------------------------------------------------

  // Default pc out of reset
  parameter addr_t RST_ADDR = 32'h0000_0200;

  // Byte step between sequential fetches
  parameter addr_t WORD_BYTES = 32'd4;

endpackage
